// File: dv/lsu_cases.txt
# op base offset wdata exp_rdata exp_misaligned exp_fault_count, all hex
# op: 0 lb, 1 lh, 2 lw, 3 lbu, 4 lhu, 5 sb, 6 sh, 7 sw
7 00000100 000 deadbeef 00000000 0 00
7 00000104 000 12345678 00000000 0 00
2 00000100 000 00000000 deadbeef 0 00
2 00000104 000 00000000 12345678 0 00
5 00000200 000 aaaaaa11 00000000 0 00
5 00000201 000 ffffff22 00000000 0 00
5 00000202 000 000000b3 00000000 0 00
5 00000203 000 00000044 00000000 0 00
2 00000200 000 00000000 44b32211 0 00
0 00000202 000 00000000 ffffffb3 0 00
3 00000202 000 00000000 000000b3 0 00
0 00000201 000 00000000 00000022 0 00
7 00000300 000 0000a5a5 00000000 0 00
6 00000302 000 1234f00d 00000000 0 00
2 00000300 000 00000000 f00da5a5 0 00
1 00000302 000 00000000 fffff00d 0 00
4 00000302 000 00000000 0000f00d 0 00
1 00000300 000 00000000 ffffa5a5 0 00
4 00000310 ff2 00000000 0000f00d 0 00
6 00000308 ff8 00007777 00000000 0 00
2 00000300 000 00000000 f00d7777 0 00
2 00000102 000 00000000 00000000 1 01
6 00000105 000 0000beef 00000000 1 02
2 00000104 000 00000000 12345678 0 02
7 00000101 000 cafef00d 00000000 1 03
2 00000100 000 00000000 deadbeef 0 03
4 000000ff 002 00000000 00000000 1 04
0 00000103 000 00000000 ffffffde 0 04
2 80000100 000 00000000 deadbeef 0 04

// File: lsu.f
common/lsu_pkg.sv
common/mem_port_if.sv
dmem/dmem.sv
src/lsu_agu.sv
src/lsu_ctrl.sv
src/lsu_fault_log.sv
src/lsu_top.sv
dv/lsu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module lsu_tb -f lsu.f -o lsu_sim

./obj_dir/lsu_sim | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
  echo "lsu simulation ok"
else
  echo "lsu simulation reported failure"
  exit 1
fi

// File: dv/lsu_tb.sv
// testbench that replays the cases file through lsu_top and checks data, faults and timing
module lsu_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import lsu_pkg::*;

  localparam string cases_file     = "dv/lsu_cases.txt";
  localparam int    reset_cycles   = 16;
  localparam int    timeout_margin = 50;

  logic        clk;
  logic        rst_n;
  logic        req;
  lsu_op_e     op;
  logic [31:0] base;
  logic [11:0] offset;
  logic [31:0] wdata;
  logic        busy;
  logic        done;
  logic        misaligned;
  logic [31:0] rdata;
  logic [7:0]  fault_count;
  logic [11:0] fault_addr;

  // one entry per line of the cases file
  logic [31:0] c_op[$];
  logic [31:0] c_base[$];
  logic [31:0] c_offset[$];
  logic [31:0] c_wdata[$];
  logic [31:0] c_rdata[$];
  logic [31:0] c_mis[$];
  logic [31:0] c_fcount[$];

  // address of the most recent misaligned case
  logic [11:0] exp_fault_addr = '0;

  int pass_count  = 0;
  int fail_count  = 0;
  int case_errs   = 0;
  int cycle_count = 0;
  int cycle_limit = 0;

  lsu_top dut0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .req         (req),
    .op          (op),
    .base        (base),
    .offset      (offset),
    .wdata       (wdata),
    .busy        (busy),
    .done        (done),
    .misaligned  (misaligned),
    .rdata       (rdata),
    .fault_count (fault_count),
    .fault_addr  (fault_addr)
  );

  always #4 clk = ~clk;

  // ##############################
  // watchdog
  // ##############################

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("run timed out waiting for done after %0d cycles", cycle_count);
      $display("*** FAILED ***");
      $finish;
    end
  end

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_op, f_base, f_off, f_wd, f_rd, f_mis, f_fc;
    fd = $fopen(cases_file, "r");
    if (fd == 0) begin
      $display("could not open %s", cases_file);
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      // skip blank lines and comment lines
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h %h %h %h", f_op, f_base, f_off, f_wd, f_rd, f_mis, f_fc);
        if (n == 7) begin
          c_op.push_back(f_op);
          c_base.push_back(f_base);
          c_offset.push_back(f_off);
          c_wdata.push_back(f_wd);
          c_rdata.push_back(f_rd);
          c_mis.push_back(f_mis);
          c_fcount.push_back(f_fc);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_case(int idx);
    lsu_op_e     cur_op;
    logic [31:0] eff;
    int          lat;
    cur_op   = lsu_op_e'(c_op[idx][2:0]);
    eff      = c_base[idx] + {{20{c_offset[idx][11]}}, c_offset[idx][11:0]};
    if (c_mis[idx][0]) begin
      exp_fault_addr = eff[11:0];
    end
    case_errs = 0;
    while (busy) @(negedge clk);
    @(posedge clk);
    req    <= 1'b1;
    op     <= cur_op;
    base   <= c_base[idx];
    offset <= c_offset[idx][11:0];
    wdata  <= c_wdata[idx];
    // sampling edge
    @(posedge clk);
    req <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
      if (busy !== 1'b1) begin
        $display("Fail %0t busy expected 1 actual %0b", $time, busy);
        case_errs++;
      end
    end while (done !== 1'b1);
    if (lat != 2) begin
      $display("Fail %0t done_latency expected 2 actual %0d", $time, lat);
      case_errs++;
    end
    if (rdata !== c_rdata[idx]) begin
      $display("Fail %0t rdata expected %08h actual %08h", $time, c_rdata[idx], rdata);
      case_errs++;
    end
    if (misaligned !== c_mis[idx][0]) begin
      $display("Fail %0t misaligned expected %0b actual %0b", $time, c_mis[idx][0], misaligned);
      case_errs++;
    end
    if (fault_count !== c_fcount[idx][7:0]) begin
      $display("Fail %0t fault_count expected %02h actual %02h", $time, c_fcount[idx][7:0],
               fault_count);
      case_errs++;
    end
    if (fault_addr !== exp_fault_addr) begin
      $display("Fail %0t fault_addr expected %03h actual %03h", $time, exp_fault_addr,
               fault_addr);
      case_errs++;
    end
    @(negedge clk);
    if (done !== 1'b0) begin
      $display("Fail %0t done expected 0 actual %0b", $time, done);
      case_errs++;
    end
    if (busy !== 1'b0) begin
      $display("Fail %0t busy expected 0 actual %0b", $time, busy);
      case_errs++;
    end
    if (case_errs == 0) pass_count++;
    else fail_count++;
    $display("case %0d %s %s", idx + 1, cur_op.name(), (case_errs == 0) ? "ok" : "mismatch");
  endtask

  initial begin
    clk    = 1'b0;
    rst_n  = 1'b0;
    req    = 1'b0;
    op     = op_lb;
    base   = '0;
    offset = '0;
    wdata  = '0;
    load_cases();
    cycle_limit = reset_cycles + 6 * c_op.size() + timeout_margin;
    if (c_op.size() == 0) begin
      $display("no cases read from %s", cases_file);
      fail_count++;
    end
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);

    // reset state before any request
    case_errs = 0;
    if (busy !== 1'b0) begin
      $display("Fail %0t busy expected 0 actual %0b", $time, busy);
      case_errs++;
    end
    if (done !== 1'b0) begin
      $display("Fail %0t done expected 0 actual %0b", $time, done);
      case_errs++;
    end
    if (misaligned !== 1'b0) begin
      $display("Fail %0t misaligned expected 0 actual %0b", $time, misaligned);
      case_errs++;
    end
    if (rdata !== 32'h0) begin
      $display("Fail %0t rdata expected 00000000 actual %08h", $time, rdata);
      case_errs++;
    end
    if (fault_count !== 8'h0) begin
      $display("Fail %0t fault_count expected 00 actual %02h", $time, fault_count);
      case_errs++;
    end
    if (fault_addr !== 12'h0) begin
      $display("Fail %0t fault_addr expected 000 actual %03h", $time, fault_addr);
      case_errs++;
    end
    if (case_errs == 0) pass_count++;
    else fail_count++;
    $display("reset state %s", (case_errs == 0) ? "ok" : "mismatch");

    for (int i = 0; i < c_op.size(); i++) begin
      run_case(i);
    end

    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: src/lsu_top.sv
// load/store unit top level, wires control, address generator, data memory and fault log
module lsu_top #(
  parameter int addr_width = 12,
  parameter int mem_words  = 1024
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  lsu_pkg::lsu_op_e      op,
  input  logic [31:0]           base,
  input  logic [11:0]           offset,
  input  logic [31:0]           wdata,
  output logic                  busy,
  output logic                  done,
  output logic                  misaligned,
  output logic [31:0]           rdata,
  output logic [7:0]            fault_count,
  output logic [addr_width-1:0] fault_addr
);
  import lsu_pkg::*;

  logic [31:0]           agu_base;
  logic [11:0]           agu_offset;
  mem_width_e            agu_width;
  logic [addr_width-1:0] eff_addr;
  logic                  agu_misaligned;
  logic                  fault;

  mem_port_if #(.addr_width(addr_width)) mem_bus ();

  lsu_ctrl #(.addr_width(addr_width)) u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .req            (req),
    .op             (op),
    .base           (base),
    .offset         (offset),
    .wdata          (wdata),
    .addr           (eff_addr),
    .misaligned     (agu_misaligned),
    .agu_base       (agu_base),
    .agu_offset     (agu_offset),
    .agu_width      (agu_width),
    .mem            (mem_bus.ctrl),
    .fault          (fault),
    .busy           (busy),
    .done           (done),
    .rdata          (rdata),
    .misaligned_out (misaligned)
  );

  lsu_agu #(.addr_width(addr_width)) u_agu (
    .base       (agu_base),
    .offset     (agu_offset),
    .width      (agu_width),
    .addr       (eff_addr),
    .misaligned (agu_misaligned)
  );

  dmem #(
    .addr_width (addr_width),
    .mem_words  (mem_words)
  ) u_dmem (
    .clk (clk),
    .mem (mem_bus.mem)
  );

  lsu_fault_log #(.addr_width(addr_width)) u_fault_log (
    .clk         (clk),
    .rst_n       (rst_n),
    .fault       (fault),
    .addr        (eff_addr),
    .fault_count (fault_count),
    .fault_addr  (fault_addr)
  );

endmodule

// File: src/lsu_fault_log.sv
// misalignment log for lsu_top, saturating fault counter and last faulting address
module lsu_fault_log #(
  parameter int addr_width = 12
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fault,
  input  logic [addr_width-1:0] addr,
  output logic [7:0]            fault_count,
  output logic [addr_width-1:0] fault_addr
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fault_count <= '0;
      fault_addr  <= '0;
    end else if (fault) begin
      // stick at 255
      if (fault_count != 8'hff) begin
        fault_count <= fault_count + 8'd1;
      end
      fault_addr <= addr;
    end
  end

endmodule

// File: src/lsu_ctrl.sv
// access FSM under lsu_top that latches one request, runs the memory cycle and pulses done
module lsu_ctrl #(
  parameter int addr_width = 12
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  lsu_pkg::lsu_op_e      op,
  input  logic [31:0]           base,
  input  logic [11:0]           offset,
  input  logic [31:0]           wdata,
  input  logic [addr_width-1:0] addr,
  input  logic                  misaligned,
  output logic [31:0]           agu_base,
  output logic [11:0]           agu_offset,
  output lsu_pkg::mem_width_e   agu_width,
  mem_port_if.ctrl              mem,
  output logic                  fault,
  output logic                  busy,
  output logic                  done,
  output logic [31:0]           rdata,
  output logic                  misaligned_out
);
  import lsu_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_access,
    st_resp
  } state_e;

  state_e      state_q;
  lsu_op_e     op_q;
  logic [31:0] base_q;
  logic [11:0] offset_q;
  logic [31:0] wdata_q;
  logic        in_access;
  logic        is_store;

  assign in_access = (state_q == st_access);
  assign is_store  = op_is_store(op_q);
  assign busy      = (state_q != st_idle);
  assign done      = (state_q == st_resp);
  assign fault     = in_access & misaligned;

  assign agu_base   = base_q;
  assign agu_offset = offset_q;
  assign agu_width  = op_width(op_q);

  // ############################
  // memory port
  // ############################

  assign mem.en          = in_access;
  assign mem.we          = in_access & is_store & ~misaligned;
  assign mem.width       = in_access ? agu_width : width_byte;
  assign mem.sign_extend = in_access & op_is_signed(op_q);
  assign mem.addr        = addr;
  assign mem.wdata       = wdata_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q        <= st_idle;
      rdata          <= '0;
      misaligned_out <= 1'b0;
    end else begin
      case (state_q)
        st_idle: begin
          if (req) begin
            state_q <= st_access;
          end
        end
        st_access: begin
          state_q        <= st_resp;
          misaligned_out <= misaligned;
          // stores and faulting loads report zero
          rdata          <= (!is_store && !misaligned) ? mem.rdata : '0;
        end
        default: begin
          state_q <= st_idle;
        end
      endcase
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (state_q == st_idle && req) begin
      op_q     <= op;
      base_q   <= base;
      offset_q <= offset;
      wdata_q  <= wdata;
    end
  end

  done_one_cycle_a: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("lsu_ctrl: done held longer than one cycle");

  no_accept_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
    (busy && req) |=> ($stable(op_q) && $stable(base_q) && $stable(offset_q) &&
                       $stable(wdata_q)))
    else $error("lsu_ctrl: request accepted while busy");

endmodule

// File: src/lsu_agu.sv
// effective address generator for lsu_ctrl, adds base and signed offset and flags misalignment
module lsu_agu #(
  parameter int addr_width = 12
) (
  input  logic [31:0]            base,
  input  logic [11:0]            offset,
  input  lsu_pkg::mem_width_e    width,
  output logic [addr_width-1:0]  addr,
  output logic                   misaligned
);
  import lsu_pkg::*;

  logic [31:0] offset_ext;
  logic [31:0] sum;

  assign offset_ext = {{20{offset[11]}}, offset};
  assign sum        = base + offset_ext;

  // byte address space of the data memory only
  assign addr = sum[addr_width-1:0];

  always_comb begin
    case (width)
      width_byte: begin
        misaligned = 1'b0;
      end
      width_half: begin
        misaligned = addr[0];
      end
      width_word: begin
        misaligned = |addr[1:0];
      end
      default: begin
        misaligned = 1'b0;
      end
    endcase
  end

endmodule

// File: dmem/dmem.sv
// word-organized data memory with byte-lane store merge and extending load path, used under lsu_top
module dmem #(
  parameter int addr_width = 12,
  parameter int mem_words  = 1024
) (
  input logic   clk,
  mem_port_if.mem mem
);
  import lsu_pkg::*;

  logic [xlen-1:0]       words [mem_words];
  logic [addr_width-3:0] word_idx;
  logic [3:0][7:0]       cur_word;
  logic [3:0][7:0]       new_word;
  logic [7:0]            byte_lane;
  logic [15:0]           half_lane;

  assign word_idx = mem.addr[addr_width-1:2];
  assign cur_word = words[word_idx];

  // ############################
  // store merge
  // ############################

  always_comb begin
    new_word = cur_word;
    case (mem.width)
      width_byte: begin
        new_word[mem.addr[1:0]] = mem.wdata[7:0];
      end
      width_half: begin
        new_word[{mem.addr[1], 1'b1}] = mem.wdata[15:8];
        new_word[{mem.addr[1], 1'b0}] = mem.wdata[7:0];
      end
      default: begin
        new_word = mem.wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (mem.en && mem.we) begin
      words[word_idx] <= new_word;
    end
  end

  // ############################
  // load extract
  // ############################

  assign byte_lane = cur_word[mem.addr[1:0]];
  // upper byte comes from the higher lane
  assign half_lane = {cur_word[{mem.addr[1], 1'b1}], cur_word[{mem.addr[1], 1'b0}]};

  always_comb begin
    case (mem.width)
      width_byte: begin
        mem.rdata = {{24{mem.sign_extend & byte_lane[7]}}, byte_lane};
      end
      width_half: begin
        mem.rdata = {{16{mem.sign_extend & half_lane[15]}}, half_lane};
      end
      width_word: begin
        mem.rdata = cur_word;
      end
      default: begin
        mem.rdata = '0;
      end
    endcase
  end

  // write strobe without enable would be a controller bug
  we_needs_en_a: assert property (@(posedge clk) mem.we |-> mem.en)
    else $error("dmem: we high while en low");

endmodule

// File: common/mem_port_if.sv
// memory port bundle between the access FSM and the data memory; instantiated once in the top level
interface mem_port_if #(
  parameter int addr_width = 12
);
  import lsu_pkg::*;

  logic                  en;
  logic                  we;
  mem_width_e            width;
  logic                  sign_extend;
  logic [addr_width-1:0] addr;
  logic [xlen-1:0]       wdata;
  // combinational read data
  logic [xlen-1:0]       rdata;

  modport ctrl (
    output en, we, width, sign_extend, addr, wdata,
    input  rdata
  );

  modport mem (
    input  en, we, width, sign_extend, addr, wdata,
    output rdata
  );

endinterface

// File: common/lsu_pkg.sv
// shared opcode and access-size types plus decode helpers, imported by every lsu block
package lsu_pkg;

  localparam int xlen = 32;

  // load/store opcodes as presented on the request port
  typedef enum logic [2:0] {
    op_lb  = 3'd0,
    op_lh  = 3'd1,
    op_lw  = 3'd2,
    op_lbu = 3'd3,
    op_lhu = 3'd4,
    op_sb  = 3'd5,
    op_sh  = 3'd6,
    op_sw  = 3'd7
  } lsu_op_e;

  typedef enum logic [1:0] {
    width_byte = 2'd0,
    width_half = 2'd1,
    width_word = 2'd2
  } mem_width_e;

  function automatic mem_width_e op_width(lsu_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return width_byte;
      op_lh, op_lhu, op_sh: return width_half;
      default:              return width_word;
    endcase
  endfunction

  function automatic logic op_is_store(lsu_op_e op);
    return op inside {op_sb, op_sh, op_sw};
  endfunction

  // only the signed loads replicate the top bit
  function automatic logic op_is_signed(lsu_op_e op);
    return op inside {op_lb, op_lh};
  endfunction

endpackage
